// ==== wfd_main.f ====
+incdir+.
wfd_main_pkg.sv
lane_fifo.sv
token_rcv.sv
panel_status.sv
wfd_main.sv
wfd_main_sva.sv
wfd_main_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = wfd_main_tb
FILELIST  = wfd_main.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = sim failed
PASS_MSG  = sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== wfd_main_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wfd_main_settings.svh"

module wfd_main_tb import wfd_main_pkg::*; ();

	localparam int DEPTH = 1 << `WFD_FIFO_ABITS;

	logic                  CLK125;
	logic                  rst_n;
	link_word_t            rx_data [`WFD_LANES];
	logic [`WFD_LANES-1:0] rx_kchar;
	logic [`WFD_LANES-1:0] rd_credit;
	logic                  ser_trig;
	logic                  inh_n;
	link_word_t            rd_data [`WFD_LANES];
	logic [`WFD_LANES-1:0] rd_valid;
	fifo_cnt_t             fifo_cnt [`WFD_LANES];
	link_word_t            tx_data;
	logic                  tx_kchar;
	logic [2:0]            led;

	link_word_t ref_q [`WFD_LANES][$];	// Words still owed per lane
	link_word_t echo_q [$];
	int         seed;
	int         mismatches;
	int         timeouts;
	bit         check_en;

	wfd_main wfd_main_inst (.CLK125(CLK125), .rst_n_i(rst_n),
		.rx_data_0_i(rx_data[0]), .rx_data_1_i(rx_data[1]),
		.rx_data_2_i(rx_data[2]), .rx_data_3_i(rx_data[3]),
		.rx_kchar_0_i(rx_kchar[0]), .rx_kchar_1_i(rx_kchar[1]),
		.rx_kchar_2_i(rx_kchar[2]), .rx_kchar_3_i(rx_kchar[3]),
		.rd_credit_0_i(rd_credit[0]), .rd_credit_1_i(rd_credit[1]),
		.rd_credit_2_i(rd_credit[2]), .rd_credit_3_i(rd_credit[3]),
		.ser_trig_i(ser_trig), .inh_n_i(inh_n),
		.rd_data_0_o(rd_data[0]), .rd_data_1_o(rd_data[1]),
		.rd_data_2_o(rd_data[2]), .rd_data_3_o(rd_data[3]),
		.rd_valid_0_o(rd_valid[0]), .rd_valid_1_o(rd_valid[1]),
		.rd_valid_2_o(rd_valid[2]), .rd_valid_3_o(rd_valid[3]),
		.fifo_cnt_0_o(fifo_cnt[0]), .fifo_cnt_1_o(fifo_cnt[1]),
		.fifo_cnt_2_o(fifo_cnt[2]), .fifo_cnt_3_o(fifo_cnt[3]),
		.tx_data_o(tx_data), .tx_kchar_o(tx_kchar), .led_o(led));

	initial begin
		CLK125 = 1'b0;
		forever #2 CLK125 = ~CLK125;
	end

	initial begin
		repeat (20000) @(posedge CLK125);
		$display("simulation ran past its cycle limit");
		$display("sim failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output monitor, mid-cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge CLK125) begin
		if (check_en) begin
			for (int n = 0; n < `WFD_LANES; n++) begin
				if (rd_valid[n]) begin	// Anything unexpected is a K word or extra
					assert (ref_q[n].size() != 0 && rd_data[n] == ref_q[n][0]) else begin
						mismatches++;
						$display("mismatch at %0t: lane %0d read %h, %0d words owed",
							$time, n, rd_data[n], ref_q[n].size());
					end
					if (ref_q[n].size() != 0) begin
						void'(ref_q[n].pop_front());
					end
				end
			end
			if (!tx_kchar) begin
				assert (echo_q.size() != 0 && tx_data == echo_q[0]) else begin
					mismatches++;
					$display("mismatch at %0t: echo word %h not expected", $time, tx_data);
				end
				if (echo_q.size() != 0) begin
					void'(echo_q.pop_front());
				end
			end else begin
				assert (tx_data == `WFD_IDLE_KCHAR) else begin
					mismatches++;
					$display("mismatch at %0t: idle word %h", $time, tx_data);
				end
			end
		end
	end

	task automatic next_cycle();
		@(posedge CLK125);
		#1;
	endtask

	function automatic bit all_drained();
		bit done;
		done = (echo_q.size() == 0);
		for (int n = 0; n < `WFD_LANES; n++) begin
			done = done && (ref_q[n].size() == 0);
		end
		return done;
	endfunction

	task automatic wait_drain(int limit);
		int n;
		n = 0;
		while (!all_drained() && n < limit) begin
			next_cycle();
			n++;
		end
		if (!all_drained()) begin
			timeouts++;
			$display("timeout: expected words still missing after %0d cycles", limit);
		end
	endtask

	task automatic wait_led(int idx, bit level, int limit);
		int n;
		n = 0;
		while (led[idx] !== level && n < limit) begin
			next_cycle();
			n++;
		end
		if (led[idx] !== level) begin
			timeouts++;
			$display("timeout: LED %0d did not go to %0b within %0d cycles", idx, level, limit);
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		rd_credit = '0;
		rx_kchar = '1;
		ser_trig = 1'b0;
		inh_n = 1'b0;
		repeat (10) next_cycle();
		rst_n = 1'b1;
		next_cycle();
		assert (led[0]) else begin
			mismatches++;
			$display("mismatch at %0t: error LED dark after reset", $time);
		end
		// Startup hold, then the error LED stretch
		wait_led(0, 1'b0, `WFD_STARTUP_CYCLES + `WFD_LED_HOLD + 16);
	endtask

	task automatic run_traffic(int cycles);
		logic [31:0] r;
		for (int c = 0; c < cycles; c++) begin
			for (int n = 0; n < `WFD_LANES; n++) begin
				r = $random(seed);
				rx_data[n] = r[31:16];
				rx_kchar[n] = r[0] | (ref_q[n].size() >= 12);	// Never overrun here
				rd_credit[n] = (r[3:2] != 2'b00);
				if (!rx_kchar[n]) begin
					ref_q[n].push_back(r[31:16]);
				end
			end
			next_cycle();
		end
		rx_kchar = '1;
	endtask

	task automatic send_token(token_t tok, bit bad);
		bit par;
		par = ~(^tok) ^ bad;	// Odd parity, flipped for a bad frame
		ser_trig = 1'b1;
		next_cycle();
		for (int i = `WFD_TOKEN_BITS - 1; i >= 0; i--) begin
			ser_trig = tok[i];
			next_cycle();
		end
		ser_trig = par;
		echo_q.push_back({1'b1, 4'b0000, bad, tok});
		next_cycle();
		ser_trig = 1'b0;
	endtask

	task automatic fill_lanes(int words);
		for (int i = 0; i < words; i++) begin
			for (int n = 0; n < `WFD_LANES; n++) begin
				rx_data[n] = {n[3:0], 12'(i)};
				rx_kchar[n] = 1'b0;
				if (i < DEPTH) begin
					ref_q[n].push_back(rx_data[n]);	// The rest is dropped
				end
			end
			next_cycle();
		end
		rx_kchar = '1;
	endtask

	initial begin
		int n;
		seed = 32'h3e24;
		mismatches = 0;
		timeouts = 0;
		check_en = 1'b0;
		for (int l = 0; l < `WFD_LANES; l++) begin
			rx_data[l] = '0;
		end
		apply_reset();
		check_en = 1'b1;

		run_traffic(1500);
		rd_credit = '1;
		wait_drain(200);
		rd_credit = '0;

		// Good frame, then a bad one
		send_token(10'h2a5, 1'b0);
		wait_drain(20);
		wait_led(1, 1'b1, 4);
		send_token(token_t'($random(seed)), 1'b1);
		wait_drain(20);
		wait_led(0, 1'b1, 4);

		inh_n = 1'b1;
		wait_led(2, 1'b1, 3);
		inh_n = 1'b0;
		wait_led(2, 1'b0, `WFD_LED_HOLD + 4);

		////////////////////////////////////////////////////////////////////////////
		// Overflow with no credits
		////////////////////////////////////////////////////////////////////////////

		apply_reset();
		fill_lanes(20);
		n = 0;
		while (fifo_cnt[0] != DEPTH && n < 8) begin
			next_cycle();
			n++;
		end
		repeat (4) next_cycle();
		for (int l = 0; l < `WFD_LANES; l++) begin
			assert (fifo_cnt[l] == fifo_cnt_t'(DEPTH)) else begin
				mismatches++;
				$display("mismatch at %0t: lane %0d holds %0d words", $time, l, fifo_cnt[l]);
			end
		end
		wait_led(0, 1'b1, 4);
		rd_credit = '1;
		wait_drain(100);
		rd_credit = '0;
		repeat (10) next_cycle();

		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, wfd_main_inst.wfd_main_sva_inst.fail_cnt);
		if (mismatches == 0 && timeouts == 0 && wfd_main_inst.wfd_main_sva_inst.fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== wfd_main_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wfd_main_settings.svh"

module wfd_main_sva import wfd_main_pkg::*; (
	input wire                  CLK125,
	input wire                  rst_n_i,	// Core reset after the startup hold
	input wire [`WFD_LANES-1:0] rd_credit_i,
	input wire [`WFD_LANES-1:0] rd_valid_i,
	input wire [`WFD_LANES-1:0] overflow_i,
	input wire                  tok_rdy_i,
	input wire                  tok_err_i,
	input wire link_word_t      tx_data_i,
	input wire                  tx_kchar_i,
	input wire                  inh_n_i,
	input wire [2:0]            led_i
);

	int fail_cnt = 0;
	int balance [`WFD_LANES];	// Credits granted minus words delivered

	always_ff @(posedge CLK125) begin
		for (int n = 0; n < `WFD_LANES; n++) begin
			if (!rst_n_i) begin
				balance[n] <= 0;
			end else begin
				balance[n] <= balance[n] + int'(rd_credit_i[n]) - int'(rd_valid_i[n]);
			end
		end
	end

	for (genvar n = 0; n < `WFD_LANES; n++) begin : g_lane
		credit_a: assert property (@(posedge CLK125) disable iff (!rst_n_i)
			rd_valid_i[n] |-> balance[n] > 0)
			else begin $error("lane %0d delivered a word without credit", n); fail_cnt++; end
	end

	reset_a: assert property (@(posedge CLK125) !rst_n_i |=> (rd_valid_i == '0) && tx_kchar_i)
		else begin $error("outputs not idle in reset"); fail_cnt++; end

	idle_a: assert property (@(posedge CLK125) disable iff (!rst_n_i)
		!tok_rdy_i |=> tx_kchar_i && tx_data_i == `WFD_IDLE_KCHAR)
		else begin $error("idle comma missing"); fail_cnt++; end

	// LED triggers
	led_err_a: assert property (@(posedge CLK125) disable iff (!rst_n_i)
		((tok_rdy_i && tok_err_i) || (|overflow_i)) |=> led_i[0])
		else begin $error("error LED dark"); fail_cnt++; end
	led_trig_a: assert property (@(posedge CLK125) disable iff (!rst_n_i) tok_rdy_i |=> led_i[1])
		else begin $error("trigger LED dark"); fail_cnt++; end
	led_inh_a: assert property (@(posedge CLK125) disable iff (!rst_n_i) inh_n_i |=> led_i[2])
		else begin $error("inhibit LED dark"); fail_cnt++; end

endmodule

bind wfd_main wfd_main_sva wfd_main_sva_inst (.CLK125(CLK125), .rst_n_i(core_rst_n),
	.rd_credit_i({rd_credit_3_i, rd_credit_2_i, rd_credit_1_i, rd_credit_0_i}),
	.rd_valid_i({rd_valid_3_o, rd_valid_2_o, rd_valid_1_o, rd_valid_0_o}),
	.overflow_i(overflow), .tok_rdy_i(tok_rdy), .tok_err_i(tok_err),
	.tx_data_i(tx_data_o), .tx_kchar_i(tx_kchar_o), .inh_n_i(inh_n_i), .led_i(led_o));

`default_nettype wire

// ==== wfd_main.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wfd_main_settings.svh"

module wfd_main import wfd_main_pkg::*; (
	input  wire             CLK125,
	input  wire             rst_n_i,
	// Receive lanes
	input  wire link_word_t rx_data_0_i,
	input  wire link_word_t rx_data_1_i,
	input  wire link_word_t rx_data_2_i,
	input  wire link_word_t rx_data_3_i,
	input  wire             rx_kchar_0_i,
	input  wire             rx_kchar_1_i,
	input  wire             rx_kchar_2_i,
	input  wire             rx_kchar_3_i,
	// Reader credits
	input  wire             rd_credit_0_i,
	input  wire             rd_credit_1_i,
	input  wire             rd_credit_2_i,
	input  wire             rd_credit_3_i,
	// Interconnect
	input  wire             ser_trig_i,
	input  wire             inh_n_i,
	// Drain side
	output link_word_t      rd_data_0_o,
	output link_word_t      rd_data_1_o,
	output link_word_t      rd_data_2_o,
	output link_word_t      rd_data_3_o,
	output logic            rd_valid_0_o,
	output logic            rd_valid_1_o,
	output logic            rd_valid_2_o,
	output logic            rd_valid_3_o,
	output fifo_cnt_t       fifo_cnt_0_o,
	output fifo_cnt_t       fifo_cnt_1_o,
	output fifo_cnt_t       fifo_cnt_2_o,
	output fifo_cnt_t       fifo_cnt_3_o,
	// Echo to all transmit lanes
	output link_word_t      tx_data_o,
	output logic            tx_kchar_o,
	output logic [2:0]      led_o
);

	logic                  core_rst_n;
	logic [`WFD_LANES-1:0] overflow;
	token_t                token;
	logic                  tok_rdy;
	logic                  tok_err;

	lane_fifo lane_0_inst (.CLK125(CLK125), .rst_n_i(core_rst_n),
		.wr_data_i(rx_data_0_i), .wr_kchar_i(rx_kchar_0_i), .rd_credit_i(rd_credit_0_i),
		.rd_data_o(rd_data_0_o), .rd_valid_o(rd_valid_0_o),
		.fifo_cnt_o(fifo_cnt_0_o), .overflow_o(overflow[0]));

	lane_fifo lane_1_inst (.CLK125(CLK125), .rst_n_i(core_rst_n),
		.wr_data_i(rx_data_1_i), .wr_kchar_i(rx_kchar_1_i), .rd_credit_i(rd_credit_1_i),
		.rd_data_o(rd_data_1_o), .rd_valid_o(rd_valid_1_o),
		.fifo_cnt_o(fifo_cnt_1_o), .overflow_o(overflow[1]));

	lane_fifo lane_2_inst (.CLK125(CLK125), .rst_n_i(core_rst_n),
		.wr_data_i(rx_data_2_i), .wr_kchar_i(rx_kchar_2_i), .rd_credit_i(rd_credit_2_i),
		.rd_data_o(rd_data_2_o), .rd_valid_o(rd_valid_2_o),
		.fifo_cnt_o(fifo_cnt_2_o), .overflow_o(overflow[2]));

	lane_fifo lane_3_inst (.CLK125(CLK125), .rst_n_i(core_rst_n),
		.wr_data_i(rx_data_3_i), .wr_kchar_i(rx_kchar_3_i), .rd_credit_i(rd_credit_3_i),
		.rd_data_o(rd_data_3_o), .rd_valid_o(rd_valid_3_o),
		.fifo_cnt_o(fifo_cnt_3_o), .overflow_o(overflow[3]));

	token_rcv token_rcv_inst (.CLK125(CLK125), .rst_n_i(core_rst_n),
		.ser_trig_i(ser_trig_i), .token_o(token), .tok_rdy_o(tok_rdy), .tok_err_o(tok_err));

	panel_status panel_status_inst (.CLK125(CLK125), .rst_n_i(rst_n_i),
		.overflow_i(overflow), .tok_rdy_i(tok_rdy), .tok_err_i(tok_err),
		.inh_n_i(inh_n_i), .core_rst_n_o(core_rst_n), .led_o(led_o));

	////////////////////////////////////////////////////////////////////////////
	// Token echo, comma fill between tokens
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!core_rst_n) begin
			tx_data_o  <= `WFD_IDLE_KCHAR;
			tx_kchar_o <= 1'b1;
		end else if (tok_rdy) begin
			tx_data_o  <= {1'b1, 4'b0000, tok_err, token};	// Marker, status, token
			tx_kchar_o <= 1'b0;
		end else begin
			tx_data_o  <= `WFD_IDLE_KCHAR;
			tx_kchar_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== panel_status.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wfd_main_settings.svh"

module panel_status (
	input  wire                   CLK125,
	input  wire                   rst_n_i,
	input  wire [`WFD_LANES-1:0]  overflow_i,
	input  wire                   tok_rdy_i,
	input  wire                   tok_err_i,
	input  wire                   inh_n_i,
	output logic                  core_rst_n_o,
	output logic [2:0]            led_o	// 0 error, 1 trigger, 2 no inhibit
);

	localparam int SW = $clog2(`WFD_STARTUP_CYCLES + 1);
	localparam int LW = $clog2(`WFD_LED_HOLD + 1);

	logic [SW-1:0] start_cnt;
	logic [LW-1:0] hold_cnt [3];
	logic [2:0]    led_trig;

	////////////////////////////////////////////////////////////////////////////
	// Startup reset hold
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			start_cnt    <= '0;
			core_rst_n_o <= 1'b0;
		end else if (!core_rst_n_o) begin
			start_cnt <= start_cnt + 1'b1;
			if (start_cnt == SW'(`WFD_STARTUP_CYCLES - 1)) begin
				core_rst_n_o <= 1'b1;
			end
		end
	end

	// LED triggers
	assign led_trig[0] = ~core_rst_n_o | (|overflow_i) | (tok_rdy_i & tok_err_i);
	assign led_trig[1] = tok_rdy_i;
	assign led_trig[2] = inh_n_i;

	// Retrigger restarts the hold
	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			hold_cnt[0] <= LW'(`WFD_LED_HOLD);	// Error lamp on through reset
			hold_cnt[1] <= '0;
			hold_cnt[2] <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (led_trig[i]) begin
					hold_cnt[i] <= LW'(`WFD_LED_HOLD);
				end else if (hold_cnt[i] != '0) begin
					hold_cnt[i] <= hold_cnt[i] - 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			led_o[i] = (hold_cnt[i] != '0);
		end
	end

endmodule

`default_nettype wire

// ==== token_rcv.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wfd_main_settings.svh"

module token_rcv import wfd_main_pkg::*; (
	input  wire    CLK125,
	input  wire    rst_n_i,
	input  wire    ser_trig_i,	// Start, token MSB first, odd parity
	output token_t token_o,
	output logic   tok_rdy_o,
	output logic   tok_err_o
);

	localparam int BW = $clog2(`WFD_TOKEN_BITS);

	tok_state_t      state;
	token_t          shift_q;
	logic [BW-1:0]   bit_cnt;

	// Shift register and captured token are payload
	always_ff @(posedge CLK125) begin
		if (state == DATA) begin
			shift_q <= {shift_q[`WFD_TOKEN_BITS-2:0], ser_trig_i};
		end
		if (state == PARITY) begin
			token_o <= shift_q;	// Held until the next frame
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			state     <= IDLE;
			bit_cnt   <= '0;
			tok_rdy_o <= 1'b0;
			tok_err_o <= 1'b0;
		end else begin
			tok_rdy_o <= 1'b0;
			case (state)
				IDLE: begin
					bit_cnt <= '0;
					if (ser_trig_i) begin
						state <= DATA;
					end
				end
				DATA: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BW'(`WFD_TOKEN_BITS - 1)) begin
						state <= PARITY;
					end
				end
				PARITY: begin
					// Data plus parity must hold an odd number of ones
					tok_err_o <= ~(^{shift_q, ser_trig_i});
					tok_rdy_o <= 1'b1;
					state     <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== lane_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wfd_main_settings.svh"

module lane_fifo import wfd_main_pkg::*; (
	input  wire             CLK125,
	input  wire             rst_n_i,
	// Link side
	input  wire link_word_t wr_data_i,
	input  wire             wr_kchar_i,
	// Reader side, one credit per pulse
	input  wire             rd_credit_i,
	output link_word_t      rd_data_o,
	output logic            rd_valid_o,
	// Status
	output fifo_cnt_t       fifo_cnt_o,
	output logic            overflow_o
);

	localparam int DEPTH = 1 << `WFD_FIFO_ABITS;

	link_word_t mem [DEPTH];

	link_word_t wr_data_q;	// Input word, one cycle behind the link
	logic       wr_vld_q;

	logic [`WFD_FIFO_ABITS-1:0] wr_ptr;
	logic [`WFD_FIFO_ABITS-1:0] rd_ptr;
	fifo_cnt_t                  cnt_q;
	credit_t                    credit_q;

	logic full;
	logic empty;
	logic wr_en;
	logic rd_en;

	assign full  = (cnt_q == fifo_cnt_t'(DEPTH));
	assign empty = (cnt_q == '0);
	assign wr_en = wr_vld_q & ~full;	// Drop when full
	assign rd_en = (credit_q != '0) & ~empty;

	assign fifo_cnt_o = cnt_q;

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		wr_data_q <= wr_data_i;
	end

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			wr_vld_q <= 1'b0;
		end else begin
			wr_vld_q <= ~wr_kchar_i;	// Commas never reach the buffer
		end
	end

	always_ff @(posedge CLK125) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side and bookkeeping
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (rd_en) begin
			rd_data_o <= mem[rd_ptr];
		end
	end

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			cnt_q      <= '0;
			credit_q   <= '0;
			rd_valid_o <= 1'b0;
			overflow_o <= 1'b0;
		end else begin
			rd_valid_o <= rd_en;
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({wr_en, rd_en})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;
			endcase

			// Grant and spend in one cycle cancel out
			case ({rd_credit_i, rd_en})
				2'b10: begin
					if (credit_q < credit_t'(`WFD_CREDIT_MAX)) begin
						credit_q <= credit_q + 1'b1;
					end
				end
				2'b01:   credit_q <= credit_q - 1'b1;
				default: credit_q <= credit_q;
			endcase

			if (wr_vld_q && full) begin
				overflow_o <= 1'b1;	// Sticky until reset
			end
		end
	end

endmodule

`default_nettype wire

// ==== wfd_main_pkg.sv ====
`default_nettype none

`include "wfd_main_settings.svh"

package wfd_main_pkg;

	// One word from a serial link
	typedef logic [15:0] link_word_t;

	// Trigger token as captured from the interconnect line
	typedef logic [`WFD_TOKEN_BITS-1:0] token_t;

	// Word count, one bit wider than the address so full is visible
	typedef logic [`WFD_FIFO_ABITS:0] fifo_cnt_t;

	typedef logic [3:0] credit_t;	// Up to WFD_CREDIT_MAX

	// Token frame receiver
	typedef enum logic [1:0] {
		IDLE,	// Waiting for start bit
		DATA,	// Shifting token bits
		PARITY	// Odd parity bit
	} tok_state_t;

endpackage

`default_nettype wire

// ==== wfd_main_settings.svh ====
`ifndef WFD_MAIN_SETTINGS_SVH
`define WFD_MAIN_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Receive lanes and their buffers
////////////////////////////////////////////////////////////////////////////

`define WFD_LANES 4             // Serial receive lanes
`define WFD_FIFO_ABITS 4        // 16 words per lane
`define WFD_CREDIT_MAX 8        // Credits a reader may hold

////////////////////////////////////////////////////////////////////////////
// Trigger token and echo
////////////////////////////////////////////////////////////////////////////

`define WFD_TOKEN_BITS 10
`define WFD_IDLE_KCHAR 16'h00BC // K28.5 comma in the low byte

////////////////////////////////////////////////////////////////////////////
// Front panel and startup
////////////////////////////////////////////////////////////////////////////

`define WFD_LED_HOLD 32         // Stretch in CLK125 cycles
`define WFD_STARTUP_CYCLES 64

`endif
